// ==== include/rv_defines.svh ====
// RV32I core constants; the core supports only a 32-bit data path and 32 registers
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// Data and address width
`define RV_XLEN 32

// Size of the integer register file
`define RV_NREGS 32

// Program counter value after reset
`define RV_RESET_PC 32'h0000_0000

// Write-back source codes carried in CtrlSig.WbSel
`define RV_WB_ALU 2'd0
`define RV_WB_MEM 2'd1
`define RV_WB_PC4 2'd2

`endif

// ==== rtl/types.sv ====
// Shared core types; widths follow rv_defines.svh, which must be on the include path
`include "rv_defines.svh"

package types;

    typedef logic [`RV_XLEN-1:0]          Word;
    typedef logic [`RV_XLEN-1:0]          Addr;
    typedef logic [31:0]                  Inst;
    typedef logic [$clog2(`RV_NREGS)-1:0] RegIdx;

    typedef enum logic [6:0] {
        OpCode_LUI    = 7'b0110111,
        OpCode_AUIPC  = 7'b0010111,
        OpCode_JAL    = 7'b1101111,
        OpCode_JALR   = 7'b1100111,
        OpCode_LOAD   = 7'b0000011,
        OpCode_STORE  = 7'b0100011,
        OpCode_OP     = 7'b0110011,
        OpCode_OP_IMM = 7'b0010011,
        OpCode_BRANCH = 7'b1100011
    } OpCode;

    typedef enum logic [3:0] {
        AluOp_ADD, AluOp_SUB, AluOp_SLL, AluOp_SLT, AluOp_SLTU, AluOp_XOR,
        AluOp_SRL, AluOp_SRA, AluOp_OR, AluOp_AND, AluOp_PassB, AluOp_Unknown
    } AluOp;

    typedef enum logic [1:0] {
        BusState_Idle = 2'd0,
        BusState_Wait = 2'd1,
        BusState_Done = 2'd2
    } BusState;

    typedef struct packed {
        logic       MemRd;
        logic       MemWr;
        logic       IsJump;
        logic       IsJalr;
        logic       IsBranch;
        logic       AluSrcA;  // 1 selects PC
        logic       AluSrcB;  // 1 selects immediate
        logic       RegWr;
        logic [1:0] WbSel;
    } CtrlSig;

    typedef struct packed {
        logic Cyc;
        logic Stb;
        logic We;
        Addr  Adr;
        Word  DatW;
    } WbMaster;

    typedef struct packed {
        logic Ack;
        Word  DatR;
    } WbSlave;

    typedef struct packed {
        logic  Valid;
        Addr   Pc;
        RegIdx Rd;
        logic  RdWr;
        Word   RdData;
    } RetireInfo;

endpackage

// ==== rtl/Controller_RV32I.sv ====
// Combinational RV32I decoder; only word loads and stores, no FENCE, SYSTEM or CSR opcodes
`include "rv_defines.svh"

module Controller_RV32I (
    input  types::Inst    i_Inst,        // Instruction word
    output types::CtrlSig o_Ctrl,        // Control bundle for the datapath
    output types::AluOp   o_AluControl,  // ALU operation
    output logic          o_Illegal      // Encoding not supported
);

    logic IsIllegal;
    logic IsADD, IsSUB, IsSLL, IsSLT, IsSLTU, IsXOR, IsSRL, IsSRA, IsOR, IsAND;
    logic IsADDI, IsSLLI, IsSLTI, IsSLTIU, IsXORI, IsSRLI, IsSRAI, IsORI, IsANDI;
    logic IsLUI, IsAUIPC, IsJAL, IsJALR, IsLW, IsSW;
    logic IsBEQ, IsBNE, IsBLT, IsBGE, IsBLTU, IsBGEU;
    logic IsTypeR;
    logic IsTypeI;

    logic [2:0] funct3;
    assign funct3 = i_Inst[14:12];

    always_comb begin
        {IsADD, IsSUB, IsSLL, IsSLT, IsSLTU, IsXOR, IsSRL, IsSRA, IsOR, IsAND} = '0;
        {IsADDI, IsSLLI, IsSLTI, IsSLTIU, IsXORI, IsSRLI, IsSRAI, IsORI, IsANDI} = '0;
        {IsLUI, IsAUIPC, IsJAL, IsJALR, IsLW, IsSW} = '0;
        {IsBEQ, IsBNE, IsBLT, IsBGE, IsBLTU, IsBGEU} = '0;
        IsIllegal = 1'b0;

        case (i_Inst[6:0])
            types::OpCode_LUI:   IsLUI = 1'b1;
            types::OpCode_AUIPC: IsAUIPC = 1'b1;
            types::OpCode_JAL:   IsJAL = 1'b1;
            types::OpCode_JALR:  IsJALR = 1'b1;
            types::OpCode_LOAD:
                if (funct3 == 3'b010) IsLW = 1'b1;
                else IsIllegal = 1'b1;  // Byte and halfword loads
            types::OpCode_STORE:
                if (funct3 == 3'b010) IsSW = 1'b1;
                else IsIllegal = 1'b1;
            types::OpCode_OP:
                case (funct3)
                    3'b000: if (i_Inst[30]) IsSUB = 1'b1;
                            else IsADD = 1'b1;
                    3'b001: IsSLL = 1'b1;
                    3'b010: IsSLT = 1'b1;
                    3'b011: IsSLTU = 1'b1;
                    3'b100: IsXOR = 1'b1;
                    3'b101: if (i_Inst[30]) IsSRA = 1'b1;
                            else IsSRL = 1'b1;
                    3'b110: IsOR = 1'b1;
                    default: IsAND = 1'b1;
                endcase
            types::OpCode_OP_IMM:
                case (funct3)
                    3'b000: IsADDI = 1'b1;
                    3'b001: IsSLLI = 1'b1;
                    3'b010: IsSLTI = 1'b1;
                    3'b011: IsSLTIU = 1'b1;
                    3'b100: IsXORI = 1'b1;
                    3'b101: if (i_Inst[30]) IsSRAI = 1'b1;  // Bit 30 set is arithmetic
                            else IsSRLI = 1'b1;
                    3'b110: IsORI = 1'b1;
                    default: IsANDI = 1'b1;
                endcase
            types::OpCode_BRANCH:
                case (funct3)
                    3'b000:  IsBEQ = 1'b1;
                    3'b001:  IsBNE = 1'b1;
                    3'b100:  IsBLT = 1'b1;
                    3'b101:  IsBGE = 1'b1;
                    3'b110:  IsBLTU = 1'b1;
                    3'b111:  IsBGEU = 1'b1;
                    default: IsIllegal = 1'b1;
                endcase
            default: IsIllegal = 1'b1;
        endcase
    end

    // Branches reuse the ALU as comparator with SUB for equality and SLT/SLTU for ordering
    always_comb begin
        if (IsADD | IsADDI | IsAUIPC | IsJAL | IsJALR | IsLW | IsSW)
            o_AluControl = types::AluOp_ADD;
        else if (IsSUB | IsBEQ | IsBNE)
            o_AluControl = types::AluOp_SUB;
        else if (IsSLL | IsSLLI)
            o_AluControl = types::AluOp_SLL;
        else if (IsSLT | IsSLTI | IsBLT | IsBGE)
            o_AluControl = types::AluOp_SLT;
        else if (IsSLTU | IsSLTIU | IsBLTU | IsBGEU)
            o_AluControl = types::AluOp_SLTU;
        else if (IsXOR | IsXORI)
            o_AluControl = types::AluOp_XOR;
        else if (IsSRL | IsSRLI)
            o_AluControl = types::AluOp_SRL;
        else if (IsSRA | IsSRAI)
            o_AluControl = types::AluOp_SRA;
        else if (IsOR | IsORI)
            o_AluControl = types::AluOp_OR;
        else if (IsAND | IsANDI)
            o_AluControl = types::AluOp_AND;
        else if (IsLUI)
            o_AluControl = types::AluOp_PassB;
        else
            o_AluControl = types::AluOp_Unknown;
    end

    always_comb begin
        IsTypeR = IsADD | IsSUB | IsSLL | IsSLT | IsSLTU | IsXOR | IsSRL | IsSRA |
                  IsOR | IsAND;
        IsTypeI = IsADDI | IsSLLI | IsSLTI | IsSLTIU | IsXORI | IsSRLI | IsSRAI |
                  IsORI | IsANDI;

        o_Ctrl.MemRd    = IsLW;
        o_Ctrl.MemWr    = IsSW;
        o_Ctrl.IsJump   = IsJAL | IsJALR;
        o_Ctrl.IsJalr   = IsJALR;
        o_Ctrl.IsBranch = IsBEQ | IsBNE | IsBLT | IsBGE | IsBLTU | IsBGEU;
        o_Ctrl.AluSrcA  = IsAUIPC | IsJAL;
        o_Ctrl.AluSrcB  = IsTypeI | IsLUI | IsAUIPC | IsJAL | IsJALR | IsLW | IsSW;
        o_Ctrl.RegWr    = IsTypeR | IsTypeI | IsLUI | IsAUIPC | IsJAL | IsJALR | IsLW;

        if (IsLW)
            o_Ctrl.WbSel = `RV_WB_MEM;
        else if (IsJAL | IsJALR)
            o_Ctrl.WbSel = `RV_WB_PC4;  // Link address
        else
            o_Ctrl.WbSel = `RV_WB_ALU;

        o_Illegal = IsIllegal;
    end

endmodule

// ==== rtl/Alu.sv ====
// Combinational RV32I ALU; shift amount is the low five bits of operand B
module Alu (
    input  types::Word  i_A,
    input  types::Word  i_B,
    input  types::AluOp i_Op,
    output types::Word  o_Result
);

    logic [4:0] shamt;
    logic       lessSigned;
    logic       lessUnsigned;

    assign shamt        = i_B[4:0];
    assign lessSigned   = $signed(i_A) < $signed(i_B);
    assign lessUnsigned = i_A < i_B;

    always_comb begin
        case (i_Op)
            types::AluOp_ADD:   o_Result = i_A + i_B;
            types::AluOp_SUB:   o_Result = i_A - i_B;
            types::AluOp_SLL:   o_Result = i_A << shamt;
            types::AluOp_SLT:   o_Result = types::Word'(lessSigned);
            types::AluOp_SLTU:  o_Result = types::Word'(lessUnsigned);
            types::AluOp_XOR:   o_Result = i_A ^ i_B;
            types::AluOp_SRL:   o_Result = i_A >> shamt;
            types::AluOp_SRA:   o_Result = $signed(i_A) >>> shamt;  // Sign fill
            types::AluOp_OR:    o_Result = i_A | i_B;
            types::AluOp_AND:   o_Result = i_A & i_B;
            types::AluOp_PassB: o_Result = i_B;
            default:            o_Result = '0;
        endcase
    end

endmodule

// ==== rtl/RegisterFile.sv ====
// Integer register file with two asynchronous reads and one clocked write; x0 reads zero
`include "rv_defines.svh"

module RegisterFile (
    input  logic         i_Clock,
    input  logic         i_rst,
    input  types::RegIdx i_RdA,
    input  types::RegIdx i_RdB,
    output types::Word   o_DataA,
    output types::Word   o_DataB,
    input  logic         i_WrEn,
    input  types::RegIdx i_WrIdx,
    input  types::Word   i_WrData
);

    types::Word regs [`RV_NREGS];

    always_ff @(posedge i_Clock) begin
        if (i_rst) begin
            for (int i = 0; i < `RV_NREGS; i++)
                regs[i] <= '0;
        end else if (i_WrEn && i_WrIdx != '0) begin
            regs[i_WrIdx] <= i_WrData;  // x0 is never written
        end
    end

    assign o_DataA = (i_RdA == '0) ? '0 : regs[i_RdA];
    assign o_DataB = (i_RdB == '0) ? '0 : regs[i_RdB];

endmodule

// ==== rtl/DataBusMaster.sv ====
// Wishbone classic master for one word access at a time; no burst, no error or retry
module DataBusMaster (
    input  logic           i_Clock,
    input  logic           i_rst,
    input  logic           i_Req,   // Access request from the core
    input  logic           i_We,
    input  types::Addr     i_Adr,
    input  types::Word     i_DatW,
    output logic           o_Done,  // One-cycle completion pulse
    output types::Word     o_DatR,
    output types::WbMaster o_Wb,
    input  types::WbSlave  i_Wb
);

    types::BusState state;
    types::Addr     adrQ;
    types::Word     datWQ;
    types::Word     datRQ;
    logic           weQ;

    always_ff @(posedge i_Clock) begin
        if (i_rst) begin
            state <= types::BusState_Idle;
        end else begin
            case (state)
                types::BusState_Idle: if (i_Req) state <= types::BusState_Wait;
                types::BusState_Wait: if (i_Wb.Ack) state <= types::BusState_Done;
                default:              state <= types::BusState_Idle;
            endcase
        end
    end

    // Request is latched so the bus stays stable while the slave stalls
    always_ff @(posedge i_Clock) begin
        if (state == types::BusState_Idle && i_Req) begin
            adrQ  <= i_Adr;
            weQ   <= i_We;
            datWQ <= i_DatW;
        end
        if (state == types::BusState_Wait && i_Wb.Ack)
            datRQ <= i_Wb.DatR;
    end

    assign o_Wb.Cyc  = (state == types::BusState_Wait);
    assign o_Wb.Stb  = (state == types::BusState_Wait);
    assign o_Wb.We   = (state == types::BusState_Wait) && weQ;
    assign o_Wb.Adr  = adrQ;
    assign o_Wb.DatW = datWQ;

    assign o_Done = (state == types::BusState_Done);
    assign o_DatR = datRQ;

endmodule

// ==== rtl/Processor_RV32I.sv ====
// Single-cycle RV32I core; combinational instruction port, halts for good on an illegal encoding
`include "rv_defines.svh"

module Processor_RV32I (
    input  logic             i_Clock,
    input  logic             i_rst,
    output types::Addr       o_InstAddr,
    input  types::Inst       i_Inst,
    output types::WbMaster   o_Wb,
    input  types::WbSlave    i_Wb,
    output types::RetireInfo o_Retire,
    output logic             o_Halted
);

    types::Addr       pc;
    logic             halted;
    types::RetireInfo retireQ;

    types::CtrlSig ctrl;
    types::AluOp   aluOp;
    logic          illegal;

    types::RegIdx rs1, rs2, rd;
    types::Word   rs1Data, rs2Data;
    types::Word   imm, aluA, aluB, aluRes, wbData, busDatR;
    types::Addr   pcPlus4, jumpTarget, nextPc;
    logic         brTaken, busDone, busReq, retireNow, rdWrEff;

    assign rs1 = i_Inst[19:15];
    assign rs2 = i_Inst[24:20];
    assign rd  = i_Inst[11:7];

    Controller_RV32I ctrl0 (
        .i_Inst(i_Inst), .o_Ctrl(ctrl), .o_AluControl(aluOp), .o_Illegal(illegal));

    RegisterFile rf0 (
        .i_Clock(i_Clock), .i_rst(i_rst), .i_RdA(rs1), .i_RdB(rs2),
        .o_DataA(rs1Data), .o_DataB(rs2Data), .i_WrEn(retireNow & ctrl.RegWr),
        .i_WrIdx(rd), .i_WrData(wbData));

    always_comb begin
        case (i_Inst[6:0])
            types::OpCode_STORE:
                imm = {{20{i_Inst[31]}}, i_Inst[31:25], i_Inst[11:7]};
            types::OpCode_BRANCH:
                imm = {{19{i_Inst[31]}}, i_Inst[31], i_Inst[7], i_Inst[30:25],
                       i_Inst[11:8], 1'b0};
            types::OpCode_LUI, types::OpCode_AUIPC:
                imm = {i_Inst[31:12], 12'b0};
            types::OpCode_JAL:
                imm = {{11{i_Inst[31]}}, i_Inst[31], i_Inst[19:12], i_Inst[20],
                       i_Inst[30:21], 1'b0};
            default:
                imm = {{20{i_Inst[31]}}, i_Inst[31:20]};  // I-type
        endcase
    end

    assign aluA = ctrl.AluSrcA ? pc : rs1Data;
    assign aluB = ctrl.AluSrcB ? imm : rs2Data;

    Alu alu0 (.i_A(aluA), .i_B(aluB), .i_Op(aluOp), .o_Result(aluRes));

    // funct3[2] picks an ordering compare over equality, funct3[0] negates it
    assign brTaken = (i_Inst[14] ? aluRes[0] : (aluRes == '0)) ^ i_Inst[12];

    assign pcPlus4    = pc + 32'd4;
    assign jumpTarget = {aluRes[31:1], aluRes[0] & ~ctrl.IsJalr};

    always_comb begin
        if (ctrl.IsJump)
            nextPc = jumpTarget;
        else if (ctrl.IsBranch && brTaken)
            nextPc = pc + imm;
        else
            nextPc = pcPlus4;
    end

    assign busReq = ~halted & (ctrl.MemRd | ctrl.MemWr);

    DataBusMaster bus0 (
        .i_Clock(i_Clock), .i_rst(i_rst), .i_Req(busReq), .i_We(ctrl.MemWr),
        .i_Adr(aluRes), .i_DatW(rs2Data), .o_Done(busDone), .o_DatR(busDatR),
        .o_Wb(o_Wb), .i_Wb(i_Wb));

    always_comb begin
        case (ctrl.WbSel)
            `RV_WB_MEM: wbData = busDatR;
            `RV_WB_PC4: wbData = pcPlus4;
            default:    wbData = aluRes;
        endcase
    end

    // Memory instructions wait for the bus to finish
    assign retireNow = ~halted & ~illegal & (~busReq | busDone);
    assign rdWrEff   = ctrl.RegWr && rd != '0;

    always_ff @(posedge i_Clock) begin
        if (i_rst) begin
            pc             <= `RV_RESET_PC;
            halted         <= 1'b0;
            retireQ.Valid  <= 1'b0;
        end else begin
            if (retireNow)
                pc <= nextPc;
            if (illegal)
                halted <= 1'b1;  // Sticky until reset
            retireQ.Valid <= retireNow;
            if (retireNow) begin
                retireQ.Pc     <= pc;
                retireQ.Rd     <= rd;
                retireQ.RdWr   <= rdWrEff;
                retireQ.RdData <= rdWrEff ? wbData : '0;
            end
        end
    end

    assign o_InstAddr = pc;
    assign o_Retire   = retireQ;
    assign o_Halted   = halted;

endmodule

// ==== dv/Processor_assertions.sv ====
// Wishbone and halt checks on one clock domain; bound into the core top and its data bus master
module Processor_assertions (
    input logic           i_Clock,
    input logic           i_rst,
    input types::WbMaster i_WbM,
    input types::WbSlave  i_WbS,
    input logic           i_Halted
);
    timeunit 1ns;
    timeprecision 1ps;

    stbInCycle: assert property (@(posedge i_Clock) disable iff (i_rst)
        i_WbM.Stb |-> i_WbM.Cyc)
        else $error("Wishbone Stb is high while Cyc is low");

    // Master holds the whole request until the slave acknowledges
    holdUntilAck: assert property (@(posedge i_Clock) disable iff (i_rst)
        (i_WbM.Stb && !i_WbS.Ack) |=> $stable(i_WbM))
        else $error("Wishbone master outputs changed before Ack");

    idleAfterReset: assert property (@(posedge i_Clock)
        $past(i_rst) |-> (!i_WbM.Cyc && !i_WbM.Stb && !i_WbM.We && !i_Halted))
        else $error("Bus or halt flag not idle right after reset");

    haltIsSticky: assert property (@(posedge i_Clock) disable iff (i_rst)
        i_Halted |=> i_Halted)
        else $error("Halt flag fell without a reset");

endmodule

bind Processor_RV32I Processor_assertions coreChecks0 (
    .i_Clock(i_Clock), .i_rst(i_rst), .i_WbM(o_Wb), .i_WbS(i_Wb), .i_Halted(o_Halted));

bind DataBusMaster Processor_assertions busChecks0 (
    .i_Clock(i_Clock), .i_rst(i_rst), .i_WbM(o_Wb), .i_WbS(i_Wb), .i_Halted(1'b0));

// ==== dv/tb_Processor.sv ====
// RV32I core testbench; data memory is 256 words, so data addresses wrap at 1 KiB
`include "rv_defines.svh"

module tb_Processor;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 4;
    localparam int PROG_MAX     = 128;

    logic             clock;
    logic             rst;
    types::Addr       instAddr;
    types::Inst       inst;
    types::WbMaster   wbOut;
    types::WbSlave    wbIn = '0;
    types::RetireInfo retire;
    logic             halted;

    types::Inst progMem [PROG_MAX];
    int         progLen = 0;
    types::Word slaveMem [256];
    types::Word refMem [256];
    types::Word refRegs [`RV_NREGS];
    types::Addr refPc;
    int         retired = 0;
    int         seed = 85;
    int         waitLeft = -1;

    Processor_RV32I dut0 (
        .i_Clock(clock),
        .i_rst(rst),
        .o_InstAddr(instAddr),
        .i_Inst(inst),
        .o_Wb(wbOut),
        .i_Wb(wbIn),
        .o_Retire(retire),
        .o_Halted(halted)
    );

    assign inst = progMem[instAddr[8:2]];  // Unused slots hold the illegal opcode zero

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    function automatic types::Inst encR(int f7, int rs2, int rs1, int f3, int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], types::OpCode_OP};
    endfunction

    function automatic types::Inst encI(int imm, int rs1, int f3, int rd, types::OpCode op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic types::Inst encS(int imm, int rs2, int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], types::OpCode_STORE};
    endfunction

    function automatic types::Inst encB(int imm, int rs2, int rs1, int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                types::OpCode_BRANCH};
    endfunction

    function automatic types::Inst encU(int imm20, int rd, types::OpCode op);
        return {imm20[19:0], rd[4:0], op};
    endfunction

    function automatic types::Inst encJ(int imm, int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], types::OpCode_JAL};
    endfunction

    function automatic types::Word fillWord(int idx);
        return {idx[7:0], ~idx[7:0], idx[7:0] ^ 8'h5A, 8'hC3};
    endfunction

    task automatic emit(types::Inst word);
        progMem[progLen] = word;
        progLen++;
    endtask

    task automatic loadProgram();
        for (int i = 0; i < PROG_MAX; i++)
            progMem[i] = '0;
        emit(encI(-5, 0, 0, 1, types::OpCode_OP_IMM));  // x1 negative and x2 positive
        emit(encI(7, 0, 0, 2, types::OpCode_OP_IMM));
        for (int f = 0; f < 8; f++)
            emit(encR(0, 2, 1, f, 3 + f));
        emit(encR(32, 2, 1, 0, 11));  // SUB
        emit(encR(32, 2, 1, 5, 12));  // SRA
        for (int f = 0; f < 8; f++)
            emit(encI((f == 1 || f == 5) ? 3 : f * 300 - 1000, 1, f, 13 + f,
                      types::OpCode_OP_IMM));
        emit(encI(32'h403, 1, 5, 21, types::OpCode_OP_IMM));  // SRAI by 3
        emit(encI(5, 1, 0, 0, types::OpCode_OP_IMM));  // x0 must stay zero
        emit(encU(32'h12345, 22, types::OpCode_LUI));
        emit(encU(1, 23, types::OpCode_AUIPC));
        emit(encJ(8, 24));
        emit(encI(1, 0, 0, 25, types::OpCode_OP_IMM));  // Skipped by JAL
        emit(encU(0, 27, types::OpCode_AUIPC));
        emit(encI(13, 27, 0, 26, types::OpCode_JALR));  // Odd target
        emit(encI(2, 0, 0, 25, types::OpCode_OP_IMM));  // Skipped by JALR
        // Three operand orders give every branch a taken and a not-taken case
        for (int f = 0; f < 8; f++) begin
            if (f == 2 || f == 3)
                continue;
            for (int p = 0; p < 3; p++) begin
                emit(encB(8, (p == 1) ? 1 : 2, (p == 0) ? 1 : 2, f));
                emit(encI(1, 28, 0, 28, types::OpCode_OP_IMM));
            end
        end
        emit(encI(256, 0, 0, 10, types::OpCode_OP_IMM));
        for (int k = 0; k < 6; k++) begin
            emit(encS(4 * k - 8, 3 + k, 10));
            emit(encI(4 * k - 8, 10, 2, 29, types::OpCode_LOAD));
        end
        emit(encI(100, 10, 2, 30, types::OpCode_LOAD));  // Word never stored
        emit(encR(0, 30, 29, 0, 31));
        emit(encI(0, 10, 0, 1, types::OpCode_LOAD));  // LB ends the program
    endtask

    function automatic types::Word opResult(logic [2:0] f3, logic alt, types::Word x,
                                            types::Word y);
        case (f3)
            3'd0: return alt ? x - y : x + y;
            3'd1: return x << y[4:0];
            3'd2: return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
            3'd3: return (x < y) ? 32'd1 : 32'd0;
            3'd4: return x ^ y;
            3'd5: begin
                if (alt)
                    return $signed(x) >>> y[4:0];
                return x >> y[4:0];
            end
            3'd6: return x | y;
            default: return x & y;
        endcase
    endfunction

    // ISA model that runs the instruction at refPc and returns Valid low on unsupported ones
    function automatic types::RetireInfo refStep();
        types::Inst       word;
        types::RetireInfo info;
        types::Word       a, b, res, immI, immS, immB, immU, immJ;
        types::Addr       nextPc, addr;
        logic [2:0]       f3;
        logic             wr, legal, take;
        word   = progMem[refPc[8:2]];
        f3     = word[14:12];
        a      = refRegs[word[19:15]];
        b      = refRegs[word[24:20]];
        immI   = {{20{word[31]}}, word[31:20]};
        immS   = {{20{word[31]}}, word[31:25], word[11:7]};
        immB   = {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
        immU   = {word[31:12], 12'h000};
        immJ   = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
        nextPc = refPc + 32'd4;
        res    = '0;
        wr     = 1'b1;
        legal  = 1'b1;
        take   = 1'b0;
        case (word[6:0])
            types::OpCode_LUI:    res = immU;
            types::OpCode_AUIPC:  res = refPc + immU;
            types::OpCode_JAL: begin
                res    = refPc + 32'd4;
                nextPc = refPc + immJ;
            end
            types::OpCode_JALR: begin
                res    = refPc + 32'd4;
                nextPc = (a + immI) & ~32'd1;
            end
            types::OpCode_OP:     res = opResult(f3, word[30], a, b);
            types::OpCode_OP_IMM: res = opResult(f3, word[30] && f3 == 3'd5, a, immI);
            types::OpCode_LOAD: begin
                addr  = a + immI;
                legal = (f3 == 3'd2);
                res   = refMem[addr[9:2]];
            end
            types::OpCode_STORE: begin
                addr  = a + immS;
                wr    = 1'b0;
                legal = (f3 == 3'd2);
                if (legal)
                    refMem[addr[9:2]] = b;
            end
            types::OpCode_BRANCH: begin
                wr = 1'b0;
                case (f3)
                    3'd0: take = (a == b);
                    3'd1: take = (a != b);
                    3'd4: take = ($signed(a) < $signed(b));
                    3'd5: take = ($signed(a) >= $signed(b));
                    3'd6: take = (a < b);
                    3'd7: take = (a >= b);
                    default: legal = 1'b0;
                endcase
                if (take)
                    nextPc = refPc + immB;
            end
            default: legal = 1'b0;
        endcase
        info = '0;
        if (!legal)
            return info;
        info.Valid  = 1'b1;
        info.Pc     = refPc;
        info.Rd     = word[11:7];
        info.RdWr   = wr && word[11:7] != 5'd0;
        info.RdData = info.RdWr ? res : '0;
        if (info.RdWr)
            refRegs[word[11:7]] = res;
        refPc = nextPc;
        return info;
    endfunction

    task automatic stopWithFailure(string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic checkAddr(string name, types::Addr got, types::Addr exp);
        if (got !== exp)
            stopWithFailure($sformatf("ERR %0t %s got %h expected %h", $time, name, got, exp));
    endtask

    task automatic checkIdx(string name, types::RegIdx got, types::RegIdx exp);
        if (got !== exp)
            stopWithFailure($sformatf("ERR %0t %s got x%0d expected x%0d", $time, name, got,
                                      exp));
    endtask

    task automatic checkWord(string name, types::Word got, types::Word exp);
        if (got !== exp)
            stopWithFailure($sformatf("ERR %0t %s got %h expected %h", $time, name, got, exp));
    endtask

    task automatic checkFlag(string name, logic got, logic exp);
        if (got !== exp)
            stopWithFailure($sformatf("ERR %0t %s got %b expected %b", $time, name, got, exp));
    endtask

    // Wishbone slave with 0 to 3 random wait states per access
    always @(negedge clock) begin
        if (rst) begin
            wbIn.Ack = 1'b0;
            waitLeft = -1;
        end else if (wbIn.Ack) begin
            wbIn.Ack = 1'b0;  // Seen by the master on the last rising edge
            waitLeft = -1;
        end else if (wbOut.Cyc && wbOut.Stb) begin
            if (waitLeft < 0)
                waitLeft = {$random(seed)} % 4;
            if (waitLeft == 0) begin
                if (wbOut.We)
                    slaveMem[wbOut.Adr[9:2]] = wbOut.DatW;
                wbIn.DatR = slaveMem[wbOut.Adr[9:2]];
                wbIn.Ack  = 1'b1;
            end else begin
                waitLeft--;
            end
        end
    end

    always @(negedge clock) begin : compareRetire
        types::RetireInfo expRet;
        if (!rst && retire.Valid) begin
            expRet = refStep();
            if (!expRet.Valid)
                stopWithFailure("DUT retired an instruction that should have trapped");
            checkAddr("o_Retire.Pc", retire.Pc, expRet.Pc);
            checkFlag("o_Retire.RdWr", retire.RdWr, expRet.RdWr);
            if (expRet.RdWr) begin
                checkIdx("o_Retire.Rd", retire.Rd, expRet.Rd);
                checkWord("o_Retire.RdData", retire.RdData, expRet.RdData);
            end
            retired++;
        end
    end

    initial begin
        @(negedge rst);
        repeat (progLen * 8 + 8) @(negedge clock);
        stopWithFailure($sformatf("Timeout: core did not halt within %0d cycles",
                                  progLen * 8 + 8));
    end

    initial begin
        types::Addr haltAddr;
        rst = 1'b1;
        loadProgram();
        for (int i = 0; i < 256; i++) begin
            slaveMem[i] = fillWord(i);
            refMem[i]   = fillWord(i);
        end
        for (int i = 0; i < `RV_NREGS; i++)
            refRegs[i] = '0;
        refPc = `RV_RESET_PC;
        repeat (RESET_CYCLES) @(negedge clock);
        rst = 1'b0;
        while (!halted)
            @(negedge clock);
        haltAddr = types::Addr'((progLen - 1) * 4);
        repeat (4) @(negedge clock);
        checkAddr("o_InstAddr", instAddr, haltAddr);  // PC frozen on the LB
        if (halted && refPc == haltAddr) begin
            $display("Halted at %h after %0d retired instructions", haltAddr, retired);
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            stopWithFailure("Core halted before retiring the whole program");
        end
    end

endmodule

// ==== sim.f ====
+incdir+include
rtl/types.sv
rtl/Controller_RV32I.sv
rtl/Alu.sv
rtl/RegisterFile.sv
rtl/DataBusMaster.sv
rtl/Processor_RV32I.sv
dv/Processor_assertions.sv
dv/tb_Processor.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass message in its output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_Processor -f sim.f \
    && ./obj_dir/Vtb_Processor | tee /dev/stderr | grep "ALL TESTS PASSED" > /dev/null \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }
exit 0
